// ==== hw/xgmii_pkg.sv ====
// shared widths, XGMII characters, column kinds and the CRC byte step; imported by every RTL file
package xgmii_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int DATA_W = 64;
    localparam int KEEP_W = 8;

    // width of the per-frame byte count handed to the counters
    localparam int LEN_W = 16;

    // default width of the statistics counters
    localparam int DEF_CNT_W = 32;

    // byte count of one beat, 1 to 8
    typedef logic [3:0] byte_cnt_t;

    // ------------------------------
    // XGMII characters
    // ------------------------------
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hFB;
    localparam logic [7:0] XGMII_TERM  = 8'hFD;
    localparam logic [7:0] XGMII_ERROR = 8'hFE;

    // start column data bytes
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    // ------------------------------
    // FCS
    // ------------------------------
    localparam logic [31:0] CRC_PRESET = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY   = 32'hEDB8_8320;

    // kind of column the encoder builds next
    typedef enum logic [2:0] {
        COL_IDLE,
        COL_START,
        COL_DATA,
        COL_TAIL_LAST,   // data, full FCS and /T/ in one column
        COL_TAIL_SPILL,  // data and the leading FCS bytes
        COL_TAIL_END,    // leftover FCS bytes, /T/, idles
        COL_ABORT
    } col_kind_t;

    // advance a reflected CRC-32 by one byte, lsb first
    function automatic logic [31:0] crc32_byte(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int b = 0; b < 8; b++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

// ==== hw/axis_tx_ctrl.sv ====
// frame FSM of the transmit adapter; accepts AXI-Stream beats, drives tready and picks column kinds
`timescale 1ns/1ns

module axis_tx_ctrl
    import xgmii_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [DATA_W-1:0] tdata_i,
    input  logic [KEEP_W-1:0] tkeep_i,
    input  logic              tvalid_i,
    input  logic              tlast_i,
    input  logic              tuser_i,
    output logic              tready_o,
    output logic              acc_o,
    output logic              clear_o,
    output logic [DATA_W-1:0] beat_data_o,
    output byte_cnt_t         tail_bytes_o,
    output col_kind_t         col_kind_o,
    output logic              frame_good_o,
    output logic              frame_bad_o,
    output logic [LEN_W-1:0]  frame_bytes_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_SPILL,
        ST_GAP,
        ST_DISCARD
    } state_t;

    state_t           state_q;
    logic             beat_acc;
    byte_cnt_t        keep_cnt;
    logic [LEN_W-1:0] byte_cnt_q;

    // number of valid lanes in a beat
    function automatic byte_cnt_t count_keep(input logic [KEEP_W-1:0] keep);
        byte_cnt_t n;
        n = '0;
        for (int i = 0; i < KEEP_W; i++) begin
            n = n + byte_cnt_t'(keep[i]);
        end
        return n;
    endfunction

    assign beat_acc = tvalid_i & tready_o;
    assign keep_cnt = count_keep(tkeep_i);

    // ------------------------------
    // control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= ST_IDLE;
            tready_o     <= 1'b0;
            col_kind_o   <= COL_IDLE;
            acc_o        <= 1'b0;
            clear_o      <= 1'b0;
            frame_good_o <= 1'b0;
            frame_bad_o  <= 1'b0;
            byte_cnt_q   <= '0;
        end else begin
            // single-cycle strobes and idle fill by default
            acc_o        <= 1'b0;
            clear_o      <= 1'b0;
            frame_good_o <= 1'b0;
            frame_bad_o  <= 1'b0;
            col_kind_o   <= COL_IDLE;
            case (state_q)
                ST_IDLE: begin
                    if (tvalid_i) begin
                        clear_o <= 1'b1;
                        state_q <= ST_START;
                    end
                end
                ST_START: begin
                    col_kind_o <= COL_START;
                    tready_o   <= 1'b1;
                    byte_cnt_q <= '0;
                    state_q    <= ST_DATA;
                end
                ST_DATA: begin
                    if (beat_acc) begin
                        acc_o <= 1'b1;
                        if (tuser_i) begin
                            // abort; the rest of the frame is swallowed
                            col_kind_o  <= COL_ABORT;
                            frame_bad_o <= 1'b1;
                            if (tlast_i) begin
                                tready_o <= 1'b0;
                                state_q  <= ST_GAP;
                            end else begin
                                state_q <= ST_DISCARD;
                            end
                        end else if (tlast_i) begin
                            tready_o     <= 1'b0;
                            frame_good_o <= 1'b1;
                            // 4 or more tail bytes push /T/ into a second column
                            if (keep_cnt >= byte_cnt_t'(4)) begin
                                col_kind_o <= COL_TAIL_SPILL;
                                state_q    <= ST_SPILL;
                            end else begin
                                col_kind_o <= COL_TAIL_LAST;
                                state_q    <= ST_GAP;
                            end
                        end else begin
                            col_kind_o <= COL_DATA;
                            byte_cnt_q <= byte_cnt_q + LEN_W'(keep_cnt);
                        end
                    end
                end
                ST_SPILL: begin
                    col_kind_o <= COL_TAIL_END;
                    state_q    <= ST_GAP;
                end
                ST_GAP: begin
                    state_q <= ST_IDLE;
                end
                ST_DISCARD: begin
                    if (beat_acc && tlast_i) begin
                        tready_o <= 1'b0;
                        state_q  <= ST_GAP;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // ------------------------------
    // beat payload
    // ------------------------------
    always_ff @(posedge clk) begin
        if (beat_acc) begin
            beat_data_o  <= tdata_i;
            tail_bytes_o <= keep_cnt;
        end
        if (beat_acc && tlast_i) begin
            frame_bytes_o <= byte_cnt_q + LEN_W'(keep_cnt);
        end
    end

endmodule

// ==== hw/crc32_tx.sv ====
// running Ethernet FCS over the accepted beats; gives the final FCS for the tail byte count
`timescale 1ns/1ns

module crc32_tx
    import xgmii_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              clear_i,
    input  logic              acc_i,
    input  logic [DATA_W-1:0] beat_data_i,
    input  byte_cnt_t         tail_bytes_i,
    output logic [31:0]       fcs_o
);

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // walk the valid lanes of the current beat, lane 0 first
    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < KEEP_W; i++) begin
            if (i < int'(tail_bytes_i)) begin
                crc_next = crc32_byte(crc_next, beat_data_i[8*i +: 8]);
            end
        end
    end

    // valid while the tail beat is presented
    assign fcs_o = ~crc_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            crc_q <= CRC_PRESET;
        end else if (clear_i) begin
            crc_q <= CRC_PRESET;
        end else if (acc_i) begin
            crc_q <= crc_next;
        end
    end

endmodule

// ==== hw/xgmii_column_encoder.sv ====
// builds and registers one XGMII column per clock from the column kind, beat data and FCS
`timescale 1ns/1ns

module xgmii_column_encoder
    import xgmii_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  col_kind_t         col_kind_i,
    input  logic [DATA_W-1:0] beat_data_i,
    input  byte_cnt_t         tail_bytes_i,
    input  logic [31:0]       fcs_i,
    output logic [DATA_W-1:0] xgmii_d_o,
    output logic [KEEP_W-1:0] xgmii_c_o
);

    logic [DATA_W-1:0] d_next;
    logic [KEEP_W-1:0] c_next;
    logic [31:0]       hold_fcs;
    byte_cnt_t         hold_n;

    // lanes of a tail column; base is 0 for the tail column and 8 for the end column
    function automatic logic [KEEP_W+DATA_W-1:0] tail_lanes(
        input logic [DATA_W-1:0] data,
        input byte_cnt_t         n,
        input logic [31:0]       fcs,
        input int                base
    );
        logic [DATA_W-1:0] d;
        logic [KEEP_W-1:0] c;
        int                k;
        d = '0;
        c = '0;
        for (int i = 0; i < KEEP_W; i++) begin
            // k is the lane's position relative to the first FCS byte
            k = base + i - int'(n);
            if (k < 0) begin
                d[8*i +: 8] = data[8*i +: 8];
            end else if (k < 4) begin
                d[8*i +: 8] = fcs[8*k +: 8];
            end else if (k == 4) begin
                d[8*i +: 8] = XGMII_TERM;
                c[i]        = 1'b1;
            end else begin
                d[8*i +: 8] = XGMII_IDLE;
                c[i]        = 1'b1;
            end
        end
        return {c, d};
    endfunction

    // ------------------------------
    // next column
    // ------------------------------
    always_comb begin
        d_next = {KEEP_W{XGMII_IDLE}};
        c_next = '1;
        case (col_kind_i)
            COL_START: begin
                d_next = {SFD_BYTE, {6{PREAMBLE_BYTE}}, XGMII_START};
                c_next = 8'h01;
            end
            COL_DATA: begin
                d_next = beat_data_i;
                c_next = '0;
            end
            COL_TAIL_LAST, COL_TAIL_SPILL: begin
                {c_next, d_next} = tail_lanes(beat_data_i, tail_bytes_i, fcs_i, 0);
            end
            COL_TAIL_END: begin
                {c_next, d_next} = tail_lanes(beat_data_i, hold_n, hold_fcs, KEEP_W);
            end
            COL_ABORT: begin
                d_next = {KEEP_W{XGMII_ERROR}};
                c_next = '1;
            end
            default: begin
                d_next = {KEEP_W{XGMII_IDLE}};
                c_next = '1;
            end
        endcase
    end

    // FCS bytes that did not fit go out in the end column
    always_ff @(posedge clk) begin
        if (col_kind_i == COL_TAIL_SPILL) begin
            hold_fcs <= fcs_i;
            hold_n   <= tail_bytes_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            xgmii_d_o <= {KEEP_W{XGMII_IDLE}};
            xgmii_c_o <= '1;
        end else begin
            xgmii_d_o <= d_next;
            xgmii_c_o <= c_next;
        end
    end

endmodule

// ==== hw/tx_frame_counters.sv ====
// saturating good-frame, bad-frame and good-octet counters driven by end-of-frame pulses
`timescale 1ns/1ns

module tx_frame_counters
    import xgmii_pkg::*;
#(
    parameter int CNT_W = DEF_CNT_W
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             frame_good_i,
    input  logic             frame_bad_i,
    input  logic [LEN_W-1:0] frame_bytes_i,
    output logic [CNT_W-1:0] good_frames_o,
    output logic [CNT_W-1:0] bad_frames_o,
    output logic [CNT_W-1:0] good_octets_o
);

    logic [CNT_W:0] octet_sum;

    // payload bytes plus the 4 FCS bytes, one bit wider to catch overflow
    assign octet_sum = {1'b0, good_octets_o} + (CNT_W+1)'(frame_bytes_i) + (CNT_W+1)'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            good_frames_o <= '0;
            bad_frames_o  <= '0;
            good_octets_o <= '0;
        end else begin
            if (frame_good_i) begin
                if (good_frames_o != '1) begin
                    good_frames_o <= good_frames_o + 1'b1;
                end
                if (octet_sum[CNT_W]) begin
                    good_octets_o <= '1;
                end else begin
                    good_octets_o <= octet_sum[CNT_W-1:0];
                end
            end
            if (frame_bad_i && bad_frames_o != '1) begin
                bad_frames_o <= bad_frames_o + 1'b1;
            end
        end
    end

endmodule

// ==== hw/axis2xgmii_tx.sv ====
// top of the AXI-Stream to XGMII transmit adapter; connects controller, CRC, encoder and counters
`timescale 1ns/1ns

module axis2xgmii_tx
    import xgmii_pkg::*;
#(
    parameter int CNT_W = DEF_CNT_W
) (
    input  logic              clk,
    input  logic              rst,
    // AXI-Stream input
    input  logic [DATA_W-1:0] tdata_i,
    input  logic [KEEP_W-1:0] tkeep_i,
    input  logic              tvalid_i,
    input  logic              tlast_i,
    input  logic              tuser_i,
    output logic              tready_o,
    // XGMII output
    output logic [DATA_W-1:0] xgmii_d_o,
    output logic [KEEP_W-1:0] xgmii_c_o,
    // statistics
    output logic [CNT_W-1:0]  good_frames_o,
    output logic [CNT_W-1:0]  bad_frames_o,
    output logic [CNT_W-1:0]  good_octets_o
);

    logic              acc;
    logic              clear;
    logic [DATA_W-1:0] beat_data;
    byte_cnt_t         tail_bytes;
    col_kind_t         col_kind;
    logic [31:0]       fcs;
    logic              frame_good;
    logic              frame_bad;
    logic [LEN_W-1:0]  frame_bytes;

    axis_tx_ctrl i_axis_tx_ctrl (
        .clk           (clk),
        .rst           (rst),
        .tdata_i       (tdata_i),
        .tkeep_i       (tkeep_i),
        .tvalid_i      (tvalid_i),
        .tlast_i       (tlast_i),
        .tuser_i       (tuser_i),
        .tready_o      (tready_o),
        .acc_o         (acc),
        .clear_o       (clear),
        .beat_data_o   (beat_data),
        .tail_bytes_o  (tail_bytes),
        .col_kind_o    (col_kind),
        .frame_good_o  (frame_good),
        .frame_bad_o   (frame_bad),
        .frame_bytes_o (frame_bytes)
    );

    crc32_tx i_crc32_tx (
        .clk          (clk),
        .rst          (rst),
        .clear_i      (clear),
        .acc_i        (acc),
        .beat_data_i  (beat_data),
        .tail_bytes_i (tail_bytes),
        .fcs_o        (fcs)
    );

    xgmii_column_encoder i_xgmii_column_encoder (
        .clk          (clk),
        .rst          (rst),
        .col_kind_i   (col_kind),
        .beat_data_i  (beat_data),
        .tail_bytes_i (tail_bytes),
        .fcs_i        (fcs),
        .xgmii_d_o    (xgmii_d_o),
        .xgmii_c_o    (xgmii_c_o)
    );

    tx_frame_counters #(
        .CNT_W (CNT_W)
    ) i_tx_frame_counters (
        .clk           (clk),
        .rst           (rst),
        .frame_good_i  (frame_good),
        .frame_bad_i   (frame_bad),
        .frame_bytes_i (frame_bytes),
        .good_frames_o (good_frames_o),
        .bad_frames_o  (bad_frames_o),
        .good_octets_o (good_octets_o)
    );

endmodule

// ==== verification/xgmii_tx_checker.sv ====
// testbench monitor for the AXI-Stream to XGMII adapter; decodes columns, compares frames and counters
`timescale 1ns/1ns

module xgmii_tx_checker
    import xgmii_pkg::*;
#(
    parameter int N_FRAMES  = 1,
    parameter int FRAME_MAX = 80,
    parameter int CNT_W     = DEF_CNT_W
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                tvalid_i,
    input  logic                tready_i,
    input  logic [DATA_W-1:0]   xgmii_d_i,
    input  logic [KEEP_W-1:0]   xgmii_c_i,
    input  logic [CNT_W-1:0]    good_frames_i,
    input  logic [CNT_W-1:0]    bad_frames_i,
    input  logic [CNT_W-1:0]    good_octets_i,
    // expected bytes per frame, payload then FCS, FRAME_MAX apart
    input  logic [7:0]          exp_mem_i [N_FRAMES*FRAME_MAX],
    input  int                  exp_len_i [N_FRAMES],
    input  logic [N_FRAMES-1:0] exp_good_i,
    input  logic [CNT_W-1:0]    exp_good_frames_i,
    input  logic [CNT_W-1:0]    exp_bad_frames_i,
    input  logic [CNT_W-1:0]    exp_octets_i,
    input  logic                end_i,
    output int                  errors_o,
    output int                  frames_o,
    output logic                done_o
);

    localparam logic [DATA_W-1:0] IDLE_D  = {KEEP_W{XGMII_IDLE}};
    localparam logic [DATA_W-1:0] START_D = {SFD_BYTE, {6{PREAMBLE_BYTE}}, XGMII_START};

    logic       in_frame;
    logic       gap_ok;
    logic       ended;
    logic       abort_col;
    logic       has_pay;
    logic       col_acc;
    logic [1:0] acc_p;
    logic [7:0] lane_d;
    logic [7:0] exp_b;
    int         cur;
    int         pos;
    int         total;
    int         pay;

    task automatic report_value(input string name, input logic [63:0] expv,
                                input logic [63:0] actv);
        $display("** Error %s: expected %0h actual %0h", name, expv, actv);
        errors_o++;
    endtask

    task automatic report_fail(input string msg);
        $display("checker: %s (time %0t)", msg, $time);
        errors_o++;
    endtask

    always @(negedge clk) begin
        if (rst) begin
            in_frame = 1'b0;
            gap_ok   = 1'b0;
            acc_p    = '0;
            errors_o = 0;
            frames_o = 0;
            done_o   = 1'b0;
        end else begin
            // a beat accepted at an edge shows up two samples later
            col_acc = acc_p[1];
            acc_p   = {acc_p[0], tvalid_i & tready_i};
            if (tready_i && !tvalid_i) begin
                report_fail("tready high while no beat is offered");
            end
            if (!in_frame) begin
                if (xgmii_c_i == 8'h01 && xgmii_d_i == START_D) begin
                    if (!gap_ok) report_fail("start column without an idle column before it");
                    if (col_acc) report_fail("beat accepted during the start column");
                    if (frames_o >= N_FRAMES) begin
                        report_fail("more frames on XGMII than in the table");
                    end else begin
                        cur      = frames_o;
                        pos      = 0;
                        total    = exp_len_i[cur];
                        pay      = exp_good_i[cur] ? total - 4 : total;
                        in_frame = 1'b1;
                    end
                end else if (xgmii_c_i == '1 && xgmii_d_i == IDLE_D) begin
                    gap_ok = 1'b1;
                end else begin
                    report_fail($sformatf("column %h/%h outside a frame", xgmii_c_i, xgmii_d_i));
                end
            end else begin
                ended     = 1'b0;
                abort_col = 1'b0;
                has_pay   = 1'b0;
                for (int i = 0; i < KEEP_W; i++) begin
                    lane_d = xgmii_d_i[8*i +: 8];
                    if (ended) begin
                        // lanes after /T/ are idle
                        if (!abort_col && !(xgmii_c_i[i] && lane_d == XGMII_IDLE)) begin
                            report_fail($sformatf("lane %0d after /T/ not idle in frame %0d",
                                                  i, cur));
                        end
                    end else if (!xgmii_c_i[i]) begin
                        if (pos < pay) has_pay = 1'b1;
                        if (pos >= total) begin
                            report_fail($sformatf("data byte past the end of frame %0d", cur));
                        end else begin
                            exp_b = exp_mem_i[cur*FRAME_MAX + pos];
                            if (lane_d !== exp_b) begin
                                report_value($sformatf("frame %0d byte %0d", cur, pos),
                                             64'(exp_b), 64'(lane_d));
                            end
                        end
                        pos++;
                    end else if (lane_d == XGMII_TERM || lane_d == XGMII_ERROR) begin
                        ended     = 1'b1;
                        abort_col = (lane_d == XGMII_ERROR);
                        if (abort_col == exp_good_i[cur]) begin
                            report_fail($sformatf("frame %0d ended with the wrong character %h",
                                                  cur, lane_d));
                        end
                        if (pos != total) begin
                            report_value($sformatf("frame %0d length", cur),
                                         64'(total), 64'(pos));
                        end
                    end else begin
                        report_fail($sformatf("control %h inside frame %0d", lane_d, cur));
                    end
                end
                if (!abort_col && has_pay != col_acc) begin
                    report_fail($sformatf("tready out of step with columns of frame %0d", cur));
                end
                if (ended) begin
                    in_frame = 1'b0;
                    gap_ok   = 1'b0;
                    frames_o++;
                end
            end
            // ------------------------------
            // statistics at the end of the run
            // ------------------------------
            if (end_i && !done_o) begin
                if (good_frames_i !== exp_good_frames_i) begin
                    report_value("good_frames", 64'(exp_good_frames_i), 64'(good_frames_i));
                end
                if (bad_frames_i !== exp_bad_frames_i) begin
                    report_value("bad_frames", 64'(exp_bad_frames_i), 64'(bad_frames_i));
                end
                if (good_octets_i !== exp_octets_i) begin
                    report_value("good_octets", 64'(exp_octets_i), 64'(good_octets_i));
                end
                done_o = 1'b1;
            end
        end
    end

endmodule

// ==== verification/tb_axis2xgmii.sv ====
// testbench top for the AXI-Stream to XGMII adapter; applies the frame table and reports the result
`timescale 1ns/1ns

module tb_axis2xgmii
    import xgmii_pkg::*;
();

    localparam int N_FRAMES   = 13;
    localparam int FRAME_MAX  = 80;
    localparam int RST_CYCLES = 5;
    localparam int CNT_W      = 32;
    localparam int DRIVE_DLY  = 1;

    // frame table of payload bytes, beat carrying tuser (-1 none) and expected good
    int frame_len  [N_FRAMES] = '{64, 65, 66, 67, 68, 69, 70, 71, 40, 23, 72,  9, 60};
    int abort_beat [N_FRAMES] = '{-1, -1, -1, -1, -1, -1, -1, -1,  2, -1,  8,  0, -1};
    bit frame_good [N_FRAMES] = '{ 1,  1,  1,  1,  1,  1,  1,  1,  0,  1,  0,  0,  1};

    logic                clk;
    logic                rst = 1'b1;
    logic [DATA_W-1:0]   tdata;
    logic [KEEP_W-1:0]   tkeep;
    logic                tvalid;
    logic                tlast;
    logic                tuser;
    logic                tready;
    logic [DATA_W-1:0]   xgmii_d;
    logic [KEEP_W-1:0]   xgmii_c;
    logic [CNT_W-1:0]    good_frames;
    logic [CNT_W-1:0]    bad_frames;
    logic [CNT_W-1:0]    good_octets;
    logic [7:0]          exp_mem [N_FRAMES*FRAME_MAX];
    int                  exp_len [N_FRAMES];
    logic [N_FRAMES-1:0] exp_good;
    logic [CNT_W-1:0]    exp_good_frames;
    logic [CNT_W-1:0]    exp_bad_frames;
    logic [CNT_W-1:0]    exp_octets;
    logic                end_check;
    logic                check_done;
    int                  errors;
    int                  frames_seen;
    logic [7:0]          payload [FRAME_MAX];
    int                  seed;
    int                  cycle_cnt;
    int                  cycle_limit;

    axis2xgmii_tx #(.CNT_W(CNT_W)) i_axis2xgmii_tx (
        .clk(clk), .rst(rst),
        .tdata_i(tdata), .tkeep_i(tkeep), .tvalid_i(tvalid), .tlast_i(tlast),
        .tuser_i(tuser), .tready_o(tready),
        .xgmii_d_o(xgmii_d), .xgmii_c_o(xgmii_c),
        .good_frames_o(good_frames), .bad_frames_o(bad_frames), .good_octets_o(good_octets)
    );

    xgmii_tx_checker #(.N_FRAMES(N_FRAMES), .FRAME_MAX(FRAME_MAX), .CNT_W(CNT_W))
    i_xgmii_tx_checker (
        .clk(clk), .rst(rst), .tvalid_i(tvalid), .tready_i(tready),
        .xgmii_d_i(xgmii_d), .xgmii_c_i(xgmii_c),
        .good_frames_i(good_frames), .bad_frames_i(bad_frames), .good_octets_i(good_octets),
        .exp_mem_i(exp_mem), .exp_len_i(exp_len), .exp_good_i(exp_good),
        .exp_good_frames_i(exp_good_frames), .exp_bad_frames_i(exp_bad_frames),
        .exp_octets_i(exp_octets), .end_i(end_check),
        .errors_o(errors), .frames_o(frames_seen), .done_o(check_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Ethernet FCS from an msb-first shift register that is bit-reversed and inverted at the end
    function automatic logic [31:0] ref_fcs(input int len);
        logic [31:0] r;
        logic [31:0] rev;
        logic        fb;
        r = 32'hFFFF_FFFF;
        for (int i = 0; i < len; i++) begin
            for (int b = 0; b < 8; b++) begin
                fb = r[31] ^ payload[i][b];
                r  = {r[30:0], 1'b0};
                if (fb) r = r ^ 32'h04C1_1DB7;
            end
        end
        for (int b = 0; b < 32; b++) begin
            rev[b] = r[31-b];
        end
        return ~rev;
    endfunction

    // called just after a rising edge; returns just after the edge that took the beat
    task automatic drive_beat(input logic [DATA_W-1:0] d, input logic [KEEP_W-1:0] k,
                              input logic last, input logic user);
        logic taken;
        tdata  = d;
        tkeep  = k;
        tlast  = last;
        tuser  = user;
        tvalid = 1'b1;
        taken  = 1'b0;
        while (!taken) begin
            taken = tready;
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic send_frame(input int f);
        int                len;
        int                nbeats;
        logic [31:0]       rnd;
        logic [31:0]       fcs;
        logic [DATA_W-1:0] d;
        logic [KEEP_W-1:0] k;
        len = frame_len[f];
        for (int i = 0; i < len; i++) begin
            rnd        = $random(seed);
            payload[i] = rnd[7:0];
        end
        fcs = ref_fcs(len);
        for (int i = 0; i < len; i++) begin
            exp_mem[f*FRAME_MAX + i] = payload[i];
        end
        for (int i = 0; i < 4; i++) begin
            exp_mem[f*FRAME_MAX + len + i] = fcs[8*i +: 8];
        end
        exp_good[f] = frame_good[f];
        if (frame_good[f]) begin
            exp_len[f]      = len + 4;
            exp_good_frames = exp_good_frames + 1;
            exp_octets      = exp_octets + CNT_W'(len + 4);
        end else begin
            // only the beats before the aborted one reach the line
            exp_len[f]     = 8 * abort_beat[f];
            exp_bad_frames = exp_bad_frames + 1;
        end
        nbeats = (len + 7) / 8;
        for (int b = 0; b < nbeats; b++) begin
            d = '0;
            k = '0;
            for (int i = 0; i < KEEP_W; i++) begin
                if (8*b + i < len) begin
                    d[8*i +: 8] = payload[8*b + i];
                    k[i]        = 1'b1;
                end
            end
            drive_beat(d, k, b == nbeats - 1, b == abort_beat[f]);
        end
    endtask

    task automatic finish_run(input bit timed_out);
        $display("checks done: frames %0d of %0d, errors %0d", frames_seen, N_FRAMES, errors);
        if (errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        seed            = 32'ha5ca;
        tdata           = '0;
        tkeep           = '0;
        tvalid          = 1'b0;
        tlast           = 1'b0;
        tuser           = 1'b0;
        end_check       = 1'b0;
        exp_good        = '0;
        exp_good_frames = '0;
        exp_bad_frames  = '0;
        exp_octets      = '0;
        cycle_cnt       = 0;
        cycle_limit     = 0;
        for (int f = 0; f < N_FRAMES; f++) begin
            exp_len[f]  = 0;
            cycle_limit = cycle_limit + (frame_len[f] + 7) / 8 + 6;
        end
        cycle_limit = 2 * cycle_limit;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        // a few idle columns before the first frame
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        for (int f = 0; f < N_FRAMES; f++) begin
            send_frame(f);
        end
        tvalid = 1'b0;
        tlast  = 1'b0;
        tuser  = 1'b0;
        while (frames_seen < N_FRAMES) @(posedge clk);
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        end_check = 1'b1;
        while (!check_done) @(posedge clk);
        finish_run(1'b0);
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt == cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            finish_run(1'b1);
        end
    end

endmodule

// ==== compile.f ====
hw/xgmii_pkg.sv
hw/axis_tx_ctrl.sv
hw/crc32_tx.sv
hw/xgmii_column_encoder.sv
hw/tx_frame_counters.sv
hw/axis2xgmii_tx.sv
verification/xgmii_tx_checker.sv
verification/tb_axis2xgmii.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the adapter testbench with Verilator; the log decides the verdict

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_axis2xgmii -o sim_tb \
    && ./obj_dir/sim_tb | tee sim.log \
    || { echo "build or simulation did not run"; exit 1; }
[ -s sim.log ] || { echo "no simulation log"; exit 1; }
grep -q "=== FAIL ===" sim.log \
    && { echo "simulation reported failure"; exit 1; } \
    || { echo "simulation finished without failure"; exit 0; }
